// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lut_mapper
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: design/lut_apb_slave.sv
module lut_apb_slave (
    input  logic                            clkb,
    input  logic                            rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [lut_pkg::APB_ADDR_W-1:0]  paddr,
    input  logic [lut_pkg::APB_DATA_W-1:0]  pwdata,
    output logic [lut_pkg::APB_DATA_W-1:0]  prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic [lut_pkg::PIX_CNT_W-1:0]   pix_count,
    output logic                            map_en,
    lut_wr_if.wr                            wr
);
    import lut_pkg::*;

    logic access;
    logic sel_ctrl;
    logic sel_status;
    logic sel_lut;
    logic decoded;
    logic [APB_ADDR_W-1:0] lut_off;

    // Access phase of a transfer, no wait states
    assign access = psel && penable;
    assign pready = access;

    // Address decode
    assign sel_ctrl = (paddr == REG_CTRL_ADDR);
    assign sel_status = (paddr == REG_STATUS_ADDR);
    assign lut_off = paddr - LUT_BASE_ADDR;
    assign sel_lut = (paddr >= LUT_BASE_ADDR) && (lut_off < LUT_WIN_BYTES);
    assign decoded = sel_ctrl || sel_status || sel_lut;

    // Table is write-only from the bus side
    assign pslverr = access && (!decoded || (sel_lut && !pwrite));

    // CTRL register
    always_ff @(posedge clkb) begin
        if (rst) begin
            map_en <= CTRL_MAP_EN_RST;
        end else if (access && pwrite && sel_ctrl) begin
            map_en <= pwdata[CTRL_MAP_EN_BIT];
        end
    end

    // Read mux, upper bits of both registers read as zero
    always_comb begin
        prdata = '0;
        if (sel_ctrl) begin
            prdata[CTRL_MAP_EN_BIT] = map_en;
        end else if (sel_status) begin
            prdata[PIX_CNT_W-1:0] = pix_count;
        end
    end

    // Port A is driven during the access phase so the write lands on its closing edge
    assign wr.en = access && sel_lut;
    assign wr.we = pwrite;
    assign wr.addr = lut_off[LUT_ADDR_W+1:2];
    assign wr.din = pwdata[LUT_DATA_W-1:0];

    // Access phase only ever follows a single setup cycle
    a_apb_phase : assert property (
        @(posedge clkb) disable iff (rst)
        penable |-> psel && $past(psel && !penable)
    );

endmodule

// File: design/lut_dpram.sv
module lut_dpram (
    input  logic                clkb,
    lut_wr_if.mem               wr,
    input  logic                rd_en,
    input  lut_pkg::pix_t       rd_addr,
    output lut_pkg::lut_entry_t rd_data
);
    import lut_pkg::*;

    // Table storage, contents come only from port A writes
    lut_entry_t mem [LUT_DEPTH];

    // Port B read register and its shift chain
    lut_entry_t rd_pipe [LUT_RD_LATENCY];

    // Port A write
    always_ff @(posedge clkb) begin
        if (wr.en && wr.we) begin
            mem[wr.addr] <= wr.din;
        end
    end

    // Port B read, old data on a same-edge collision
    always_ff @(posedge clkb) begin
        if (rd_en) begin
            rd_pipe[0] <= mem[rd_addr];
        end
    end

    // Remaining latency stages
    always_ff @(posedge clkb) begin
        for (int i = 1; i < LUT_RD_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rd_data = rd_pipe[LUT_RD_LATENCY-1];

    // Addresses from the bus block and the stream side must be clean when used
    a_wr_addr_known : assert property (
        @(posedge clkb)
        wr.en |-> !$isunknown(wr.addr)
    );

    a_rd_addr_known : assert property (
        @(posedge clkb)
        rd_en |-> !$isunknown(rd_addr)
    );

endmodule

// File: design/lut_mapper_top.sv
module lut_mapper_top (
    input  logic                           clkb,
    input  logic                           rst,
    // APB
    input  logic                           psel,
    input  logic                           penable,
    input  logic                           pwrite,
    input  logic [lut_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [lut_pkg::APB_DATA_W-1:0] pwdata,
    output logic [lut_pkg::APB_DATA_W-1:0] prdata,
    output logic                           pready,
    output logic                           pslverr,
    // Pixel stream
    input  logic                           pix_valid_in,
    input  lut_pkg::pix_t                  pix_in,
    output logic                           pix_valid_out,
    output lut_pkg::lut_entry_t            pix_out
);
    import lut_pkg::*;

    logic map_en;
    logic rd_en;
    pix_t rd_addr;
    lut_entry_t rd_data;
    logic [PIX_CNT_W-1:0] pix_count;

    // Table write port A
    lut_wr_if i_wr_if ();

    lut_apb_slave i_apb (
        .clkb      (clkb),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pix_count (pix_count),
        .map_en    (map_en),
        .wr        (i_wr_if.wr)
    );

    lut_dpram i_mem (
        .clkb    (clkb),
        .wr      (i_wr_if.mem),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    lut_stream_map i_map (
        .clkb          (clkb),
        .rst           (rst),
        .map_en        (map_en),
        .pix_valid_in  (pix_valid_in),
        .pix_in        (pix_in),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .pix_valid_out (pix_valid_out),
        .pix_out       (pix_out),
        .pix_count     (pix_count)
    );

endmodule

// File: design/lut_pkg.sv
package lut_pkg;

    // Pixel and table geometry
    localparam int LUT_ADDR_W = 10;
    localparam int LUT_DATA_W = 12;
    localparam int LUT_DEPTH = 1 << LUT_ADDR_W;

    // Port B read register plus one shift stage
    localparam int LUT_RD_LATENCY = 2;

    // APB bus widths
    localparam int APB_ADDR_W = 13;
    localparam int APB_DATA_W = 32;

    // Register map, byte addresses
    localparam logic [APB_ADDR_W-1:0] REG_CTRL_ADDR = 13'h000;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS_ADDR = 13'h004;
    localparam logic [APB_ADDR_W-1:0] LUT_BASE_ADDR = 13'h1000;

    // One 32-bit word per table entry
    localparam int LUT_WIN_BYTES = 4 * LUT_DEPTH;

    // CTRL fields
    localparam int CTRL_MAP_EN_BIT = 0;
    localparam logic CTRL_MAP_EN_RST = 1'b0;

    // STATUS pixel counter width, wraps
    localparam int PIX_CNT_W = 16;

    typedef logic [LUT_DATA_W-1:0] lut_entry_t;
    typedef logic [LUT_ADDR_W-1:0] pix_t;

endpackage

// File: design/lut_stream_map.sv
module lut_stream_map (
    input  logic                          clkb,
    input  logic                          rst,
    input  logic                          map_en,
    input  logic                          pix_valid_in,
    input  lut_pkg::pix_t                 pix_in,
    output logic                          rd_en,
    output lut_pkg::pix_t                 rd_addr,
    input  lut_pkg::lut_entry_t           rd_data,
    output logic                          pix_valid_out,
    output lut_pkg::lut_entry_t           pix_out,
    output logic [lut_pkg::PIX_CNT_W-1:0] pix_count
);
    import lut_pkg::*;

    // Side pipe, same depth as the table read path
    logic [LUT_RD_LATENCY-1:0] vld_pipe;
    logic [LUT_RD_LATENCY-1:0] mode_pipe;
    lut_entry_t byp_pipe [LUT_RD_LATENCY];

    lut_entry_t byp_in;

    // Every valid pixel goes straight to port B
    assign rd_en = pix_valid_in;
    assign rd_addr = pix_in;

    // Bypass scales the pixel up to the output width
    assign byp_in = {pix_in, 2'b00};

    // Valid and mode, mode captured with the pixel
    always_ff @(posedge clkb) begin
        if (rst) begin
            vld_pipe <= '0;
            mode_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[LUT_RD_LATENCY-2:0], pix_valid_in};
            mode_pipe <= {mode_pipe[LUT_RD_LATENCY-2:0], map_en};
        end
    end

    // Bypass payload
    always_ff @(posedge clkb) begin
        byp_pipe[0] <= byp_in;
        for (int i = 1; i < LUT_RD_LATENCY; i++) begin
            byp_pipe[i] <= byp_pipe[i-1];
        end
    end

    // Output stage
    always_ff @(posedge clkb) begin
        if (rst) begin
            pix_valid_out <= 1'b0;
        end else begin
            pix_valid_out <= vld_pipe[LUT_RD_LATENCY-1];
        end
    end

    always_ff @(posedge clkb) begin
        if (vld_pipe[LUT_RD_LATENCY-1]) begin
            pix_out <= mode_pipe[LUT_RD_LATENCY-1] ? rd_data : byp_pipe[LUT_RD_LATENCY-1];
        end
    end

    // Output pixel counter, wraps
    always_ff @(posedge clkb) begin
        if (rst) begin
            pix_count <= '0;
        end else if (pix_valid_out) begin
            pix_count <= pix_count + 1'b1;
        end
    end

    // Catches reads of table entries that were never loaded
    a_pix_out_known : assert property (
        @(posedge clkb) disable iff (rst)
        pix_valid_out |-> !$isunknown(pix_out)
    );

endmodule

// File: design/lut_wr_if.sv
interface lut_wr_if;
    import lut_pkg::*;

    // Table write port A
    logic en;
    logic we;
    pix_t addr;
    lut_entry_t din;

    // Driven by the APB register block
    modport wr (
        output en,
        output we,
        output addr,
        output din
    );

    // Consumed by the table memory
    modport mem (
        input en,
        input we,
        input addr,
        input din
    );

endinterface

// File: dv/lut_stim.txt
# Columns: W addr wdata exp_pslverr | R addr exp_prdata exp_pslverr | P pixel exp_out
#          I idle_cycles | E end; all numbers hex, APB addresses are byte addresses
# Registers after reset
R 0000 00000000 0
R 0004 00000000 0
I 2
# Bypass, output is the pixel times four
P 000 000
P 3ff ffc
P 001 004
P 155 554
P 2aa aa8
I 4
R 0004 00000005 0
# Table load, entry n at 0x1000 + 4n, only the low 12 bits count
W 1000 00000abc 0
W 1ffc 00000123 0
W 1004 fffff5a5 0
W 1554 00000777 0
W 1aa8 00000001 0
# Table mode on, back-to-back stream
W 0000 00000001 0
R 0000 00000001 0
P 000 abc
P 3ff 123
P 001 5a5
P 155 777
P 2aa 001
P 000 abc
I 4
R 0004 0000000b 0
# Entry rewritten between two pixels
P 155 777
W 1554 00000246 0
P 155 246
# Mode change between two pixels, upper CTRL bits ignored
P 2aa 001
W 0000 00000000 0
P 2aa aa8
W 0000 fffffffd 0
R 0000 00000001 0
# Error responses
R 1000 00000000 1
R 1ffc 00000000 1
R 0008 00000000 1
R 0ffc 00000000 1
W 0008 00000000 1
W 0ffc 00000000 1
# CTRL and table untouched by the undecoded writes
R 0000 00000001 0
P 3ff 123
P 155 246
P 000 abc
I 4
R 0004 00000012 0
E

// File: dv/tb_lut_mapper.sv
module tb_lut_mapper;
    import lut_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    // Pixel sampled at edge k is at the output after edge k+2
    localparam int PIX_LATENCY = 2;
    localparam int DRAIN_TIMEOUT = 20;
    localparam int MAX_COMMANDS = 500;
    localparam string STIM_FILE = "dv/lut_stim.txt";

    logic clkb;
    logic rst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic pready;
    logic pslverr;
    logic pix_valid_in;
    pix_t pix_in;
    logic pix_valid_out;
    lut_entry_t pix_out;

    // Expected value and sampling edge of each pixel in flight
    lut_entry_t exp_q[$];
    int edge_q[$];
    int cyc = 0;

    lut_mapper_top i_dut (
        .clkb          (clkb),
        .rst           (rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .pix_valid_in  (pix_valid_in),
        .pix_in        (pix_in),
        .pix_valid_out (pix_valid_out),
        .pix_out       (pix_out)
    );

    initial begin
        clkb = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clkb = ~clkb;
        end
    end

    // Rising edges seen so far
    always @(posedge clkb) begin
        cyc <= cyc + 1;
    end

    task automatic stop_run();
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_entry(input string name, input lut_entry_t exp, input lut_entry_t act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected 0x%03h, got 0x%03h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input logic [APB_DATA_W-1:0] exp,
                              input logic [APB_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            stop_run();
        end
    endtask

    // Skips blanks and comment lines and returns zero at end of file
    function automatic logic [7:0] next_command(input int fd);
        int c;
        logic [7:0] ch;
        logic skip;
        ch = 8'h00;
        skip = 1'b1;
        while (skip) begin
            c = $fgetc(fd);
            if (c < 0) begin
                ch = 8'h00;
                skip = 1'b0;
            end else begin
                ch = c[7:0];
                if (ch == "#") begin
                    while (c >= 0 && c[7:0] != "\n") begin
                        c = $fgetc(fd);
                    end
                end else if (ch != " " && ch != "\t" && ch != "\n" && ch != "\r") begin
                    skip = 1'b0;
                end
            end
        end
        return ch;
    endfunction

    task automatic expect_fields(input int got, input int want, input string cmd);
        if (got != want) begin
            $display("Stim file has a %s command with %0d fields instead of %0d", cmd, got, want);
            stop_run();
        end
    endtask

    // One APB transfer with a setup phase and a single access phase
    task automatic apb_xfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                            input logic [APB_DATA_W-1:0] wdata,
                            output logic [APB_DATA_W-1:0] rdata, output logic err);
        @(negedge clkb);
        pix_valid_in = 1'b0;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clkb);
        penable = 1'b1;
        // Slave has no wait states so pready is high in the first access cycle
        @(negedge clkb);
        check_bit("pready", 1'b1, pready);
        rdata = prdata;
        err = pslverr;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic drive_pixel(input pix_t pix, input lut_entry_t exp);
        @(negedge clkb);
        pix_valid_in = 1'b1;
        pix_in = pix;
        exp_q.push_back(exp);
        edge_q.push_back(cyc + 1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clkb);
            pix_valid_in = 1'b0;
        end
    endtask

    // Output monitor on registered outputs at the falling edge
    always @(negedge clkb) begin
        if (!rst) begin
            if (pix_valid_out === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Output pixel at %0t with no input pixel in flight", $time);
                    stop_run();
                end else if (cyc != edge_q[0] + PIX_LATENCY) begin
                    $display("Error at %0t: pix_valid_out latency expected %0d, got %0d",
                             $time, PIX_LATENCY, cyc - edge_q[0]);
                    stop_run();
                end else begin
                    check_entry("pix_out", exp_q[0], pix_out);
                    void'(exp_q.pop_front());
                    void'(edge_q.pop_front());
                end
            end else if (pix_valid_out !== 1'b0) begin
                $display("pix_valid_out is unknown at %0t", $time);
                stop_run();
            end else if (edge_q.size() != 0 && cyc > edge_q[0] + PIX_LATENCY) begin
                $display("Pixel sampled at edge %0d never reached the output", edge_q[0]);
                stop_run();
            end
        end
    end

    initial begin : main
        int fd;
        int n;
        logic [7:0] cmd;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_c;
        logic [APB_DATA_W-1:0] rdata;
        logic err;
        logic ended;
        logic drained;

        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pix_valid_in = 1'b0;
        pix_in = '0;
        ended = 1'b0;
        drained = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file %s", STIM_FILE);
            stop_run();
        end

        repeat (RESET_CYCLES) @(negedge clkb);
        rst = 1'b0;
        check_bit("pix_valid_out", 1'b0, pix_valid_out);
        check_bit("pslverr", 1'b0, pslverr);

        for (int line = 0; line < MAX_COMMANDS && !ended; line++) begin
            cmd = next_command(fd);
            case (cmd)
                "W": begin
                    n = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
                    expect_fields(n, 3, "W");
                    apb_xfer(1'b1, f_a[APB_ADDR_W-1:0], f_b, rdata, err);
                    check_bit("pslverr", f_c[0], err);
                end
                "R": begin
                    n = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
                    expect_fields(n, 3, "R");
                    apb_xfer(1'b0, f_a[APB_ADDR_W-1:0], '0, rdata, err);
                    check_bit("pslverr", f_c[0], err);
                    // Read data is only defined for an OKAY response
                    if (!f_c[0]) begin
                        check_word("prdata", f_b, rdata);
                    end
                end
                "P": begin
                    n = $fscanf(fd, "%h %h", f_a, f_b);
                    expect_fields(n, 2, "P");
                    drive_pixel(f_a[LUT_ADDR_W-1:0], f_b[LUT_DATA_W-1:0]);
                end
                "I": begin
                    n = $fscanf(fd, "%h", f_a);
                    expect_fields(n, 1, "I");
                    idle_cycles(int'(f_a));
                end
                "E": begin
                    ended = 1'b1;
                end
                8'h00: begin
                    $display("Stimulus file ended without an E command");
                    stop_run();
                end
                default: begin
                    $display("Unknown command %c in stimulus file", cmd);
                    stop_run();
                end
            endcase
        end
        $fclose(fd);

        if (!ended) begin
            $display("Stimulus file exceeds %0d commands", MAX_COMMANDS);
            stop_run();
        end

        // Let the pixels still in flight come out
        for (int i = 0; i < DRAIN_TIMEOUT && !drained; i++) begin
            @(negedge clkb);
            pix_valid_in = 1'b0;
            drained = (exp_q.size() == 0);
        end

        if (!drained) begin
            $display("%0d pixels still missing at the end of the run", exp_q.size());
            stop_run();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
design/lut_pkg.sv
design/lut_wr_if.sv
design/lut_apb_slave.sv
design/lut_dpram.sv
design/lut_stream_map.sv
design/lut_mapper_top.sv
dv/tb_lut_mapper.sv
